/* list.f */
lsu_pkg.sv
dc_array.sv
lsu_agu.sv
lsu_dcache.sv
lsu_ex.sv
lsu_top.sv
tb_lsu.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - lsu_pkg.sv
  - dc_array.sv
  - lsu_agu.sv
  - lsu_dcache.sv
  - lsu_ex.sv
  - lsu_top.sv
  - target: test
    files:
      - tb_lsu.sv

/* tb_lsu.sv */
// Directed testbench for the load/store pipeline that checks each result three cycles after issue.
`timescale 1ns/1ps

module tb_lsu
    import lsu_pkg::*;
();

    localparam int DC_SETS = 16;
    localparam int LINE_BYTES = LINE_WORDS * BYTE_LANES;
    localparam int RESET_CYCLES = 10;
    localparam int STREAM_OPS = 200;
    // directed tests take under 100 cycles and the stream one per op.
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 100 + STREAM_OPS + 50;

    typedef struct packed {
        logic     valid;
        lsu_req_t req;
    } pend_t;

    logic      clk;
    logic      i_reset;
    logic      i_flush;
    logic      i_req_valid;
    lsu_req_t  i_req;
    logic      i_fill_valid;
    lsu_fill_t i_fill;
    logic      o_cdb_valid;
    lsu_cdb_t  o_cdb;
    logic      o_miss_valid;
    lsu_miss_t o_miss;

    logic [7:0]            mem_model [logic [ADDR_WIDTH-1:0]];
    logic [ADDR_WIDTH-1:0] set_line [DC_SETS];   // installed line per set.
    logic                  set_filled [DC_SETS];
    pend_t                 pending [$];
    logic [TAG_WIDTH-1:0]  next_tag;
    int                    cycles = 0;

    lsu_top #(.DC_SETS(DC_SETS)) lsu_top_inst (
        .i_clk(clk),
        .i_reset(i_reset),
        .i_flush(i_flush),
        .i_req_valid(i_req_valid),
        .i_req(i_req),
        .i_fill_valid(i_fill_valid),
        .i_fill(i_fill),
        .o_cdb_valid(o_cdb_valid),
        .o_cdb(o_cdb),
        .o_miss_valid(o_miss_valid),
        .o_miss(o_miss)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            fail_run($sformatf("run timed out after %0d cycles", cycles));
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    function automatic int set_of(input logic [ADDR_WIDTH-1:0] addr);
        return int'((addr >> LINE_OFFSET_WIDTH) % DC_SETS);
    endfunction

    function automatic logic line_present(input logic [ADDR_WIDTH-1:0] line_addr);
        return set_filled[set_of(line_addr)] && (set_line[set_of(line_addr)] == line_addr);
    endfunction

    // aligned word from the model, shifted down to the access, then extended.
    function automatic logic [31:0] load_value(input lsu_func_t func, input logic [31:0] addr);
        logic [31:0] word;
        for (int i = 0; i < 4; i++) begin
            word[8*i +: 8] = mem_model[{addr[31:2], 2'b00} + i];
        end
        word = word >> (8 * addr[1:0]);
        case (func)
            LSU_LB:  return {{24{word[7]}}, word[7:0]};
            LSU_LBU: return {24'h0, word[7:0]};
            LSU_LH:  return {{16{word[15]}}, word[15:0]};
            LSU_LHU: return {16'h0, word[15:0]};
            default: return word;
        endcase
    endfunction

    function automatic void apply_store(input lsu_func_t func, input logic [31:0] addr,
                                        input logic [31:0] data);
        int n;
        n = (func == LSU_SB) ? 1 : (func == LSU_SH) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            mem_model[addr + i] = data[8*i +: 8];
        end
    endfunction

    task automatic check_output(input pend_t p);
        logic [31:0] addr;
        logic [31:0] line_addr;
        logic        hit;
        logic        is_store;
        addr      = p.req.base + p.req.offset;
        line_addr = {addr[31:LINE_OFFSET_WIDTH], {LINE_OFFSET_WIDTH{1'b0}}};
        hit       = line_present(line_addr);
        is_store  = p.req.func inside {LSU_SB, LSU_SH, LSU_SW};
        if (o_cdb_valid !== (p.valid && hit) || o_miss_valid !== (p.valid && !hit)) begin
            fail_run($sformatf("unexpected strobes, completion %b miss %b for live %b hit %b",
                               o_cdb_valid, o_miss_valid, p.valid, hit));
        end
        if (p.valid && !hit) begin
            check_value("o_miss.addr", o_miss.addr, line_addr);
            check_value("o_miss.tag", o_miss.tag, p.req.tag);
        end else if (p.valid) begin
            check_value("o_cdb.data", o_cdb.data, is_store ? 32'h0 : load_value(p.req.func, addr));
            check_value("o_cdb.addr", o_cdb.addr, addr);
            check_value("o_cdb.tag", o_cdb.tag, p.req.tag);
            if (is_store) begin
                apply_store(p.req.func, addr, p.req.data);
            end
        end
    endtask

    // drives one cycle and checks the op issued three cycles earlier.
    task automatic step(input logic req_valid, input lsu_req_t req, input logic flush);
        pend_t cur;
        cur.valid   = req_valid & ~flush;
        cur.req     = req;
        i_req_valid = req_valid;
        i_req       = req;
        i_flush     = flush;
        if (flush) begin
            pending[pending.size()-1].valid = 1'b0;   // two ops behind die too.
            pending[pending.size()-2].valid = 1'b0;
        end
        pending.push_back(cur);
        @(posedge clk);
        #1;
        i_req_valid = 1'b0;
        i_flush     = 1'b0;
        check_output(pending.pop_front());
    endtask

    task automatic idle(input int n);
        repeat (n) step(1'b0, '0, 1'b0);
    endtask

    task automatic issue(input lsu_func_t func, input logic [31:0] addr,
                         input logic [31:0] data, input logic flush = 1'b0);
        lsu_req_t req;
        req.func   = func;
        req.base   = $urandom;
        req.offset = addr - req.base;   // random split of the address.
        req.data   = data;
        req.tag    = next_tag;
        next_tag++;
        step(1'b1, req, flush);
    endtask

    task automatic fill_line(input logic [31:0] line_addr, input logic [7:0] force_bits);
        logic [8*LINE_BYTES-1:0] bytes;
        for (int i = 0; i < LINE_BYTES; i++) begin
            bytes[8*i +: 8] = 8'($urandom) | force_bits;
        end
        i_fill_valid = 1'b1;
        i_fill.addr  = line_addr;
        i_fill.line  = bytes;
        idle(1);
        i_fill_valid = 1'b0;
        for (int i = 0; i < LINE_BYTES; i++) begin
            mem_model[line_addr + i] = bytes[8*i +: 8];
        end
        set_line[set_of(line_addr)]   = line_addr;
        set_filled[set_of(line_addr)] = 1'b1;
    endtask

    task automatic miss_then_fill();
        issue(LSU_LW, $urandom & 32'hFFFF_FFFC, 32'h0);
        issue(LSU_LW, 32'h4000_001C, 32'h0);   // line that gets filled next.
        idle(3);
        fill_line(32'h4000_0010, 8'h00);
        for (int w = 0; w < LINE_WORDS; w++) begin
            issue(LSU_LW, 32'h4000_0010 + 4 * w, 32'h0);
        end
        idle(3);
    endtask

    // every byte has bit 7 set, so sign and zero extension differ.
    task automatic load_extension();
        fill_line(32'h8000_0020, 8'h80);
        for (int b = 0; b < 8; b++) begin
            issue(LSU_LB, 32'h8000_0020 + b, $urandom);
            issue(LSU_LBU, 32'h8000_0020 + b, $urandom);
        end
        for (int h = 0; h < 8; h += 2) begin
            issue(LSU_LH, 32'h8000_0020 + h, $urandom);
            issue(LSU_LHU, 32'h8000_0020 + h, $urandom);
        end
        idle(3);
    endtask

    task automatic store_lanes();
        fill_line(32'h0000_0130, 8'h00);
        issue(LSU_SB, 32'h0000_0131, $urandom);
        issue(LSU_LW, 32'h0000_0130, 32'h0);   // right behind the store.
        issue(LSU_SH, 32'h0000_0136, $urandom);
        issue(LSU_LW, 32'h0000_0134, 32'h0);
        issue(LSU_SW, 32'h0000_0138, $urandom);
        issue(LSU_LW, 32'h0000_0138, 32'h0);
        issue(LSU_LW, 32'h0000_013C, 32'h0);
        idle(3);
    endtask

    task automatic miss_leaves_no_trace();
        issue(LSU_SW, 32'h7000_0554, $urandom);
        issue(LSU_LW, 32'h7000_0554, 32'h0);
        issue(LSU_SB, 32'h5000_0013, $urandom);   // same set as a filled line with another tag.
        issue(LSU_LW, 32'h4000_0010, 32'h0);
        idle(3);
        fill_line(32'h7000_0550, 8'h00);
        issue(LSU_LW, 32'h7000_0554, 32'h0);
        idle(3);
    endtask

    task automatic flush_drop();
        issue(LSU_LW, 32'h0000_013C, 32'h0);   // three ahead of the flush so it completes.
        issue(LSU_SW, 32'h0000_0130, $urandom);
        issue(LSU_SB, 32'h0000_0134, $urandom);
        issue(LSU_SW, 32'h0000_0138, $urandom, 1'b1);
        issue(LSU_LW, 32'h0000_0130, 32'h0);
        issue(LSU_LW, 32'h0000_0134, 32'h0);
        issue(LSU_LW, 32'h0000_0138, 32'h0);
        idle(3);
    endtask

    task automatic random_stream();
        logic [31:0] lines [4];
        lsu_func_t   func;
        logic [31:0] offset;
        lines = '{32'h0000_2040, 32'h1234_5650, 32'hFFFF_FF60, 32'h0ABC_0070};
        foreach (lines[i]) begin
            fill_line(lines[i], 8'h00);
        end
        for (int n = 0; n < STREAM_OPS; n++) begin
            func   = lsu_func_t'($urandom_range(7, 0));
            offset = $urandom_range(LINE_BYTES - 1, 0);
            if (func inside {LSU_LH, LSU_LHU, LSU_SH}) begin
                offset[0] = 1'b0;
            end else if (func inside {LSU_LW, LSU_SW}) begin
                offset[1:0] = 2'b00;
            end
            issue(func, lines[$urandom_range(3, 0)] + offset, $urandom);
        end
        idle(3);
    endtask

    initial begin
        void'($urandom(24737));
        i_reset      = 1'b1;
        i_flush      = 1'b0;
        i_req_valid  = 1'b0;
        i_req        = '0;
        i_fill_valid = 1'b0;
        i_fill       = '0;
        next_tag     = '0;
        foreach (set_filled[s]) begin
            set_filled[s] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        i_reset = 1'b0;
        repeat (3) pending.push_back('0);   // empty pipeline.
        miss_then_fill();
        load_extension();
        store_lanes();
        miss_leaves_no_trace();
        flush_drop();
        random_stream();
        $display("All tests passed");
        $finish;
    end

endmodule

/* lsu_top.sv */
// Load/store pipeline top joining address generation, data cache and result stage.
`timescale 1ns/1ps

module lsu_top
    import lsu_pkg::*;
#(
    parameter int DC_SETS = 16
) (
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_flush,

    input  logic      i_req_valid,
    input  lsu_req_t  i_req,

    input  logic      i_fill_valid,
    input  lsu_fill_t i_fill,

    output logic      o_cdb_valid,
    output lsu_cdb_t  o_cdb,

    output logic      o_miss_valid,
    output lsu_miss_t o_miss
);

    logic                  ad_valid;
    lsu_op_t               ad_op;
    logic                  res_valid;
    lsu_op_t               res_op;
    logic                  res_hit;
    logic [DATA_WIDTH-1:0] res_word;

    lsu_agu lsu_agu_inst (
        .i_clk(i_clk),
        .i_reset(i_reset),
        .i_flush(i_flush),
        .i_req_valid(i_req_valid),
        .i_req(i_req),
        .o_op_valid(ad_valid),
        .o_op(ad_op)
    );

    lsu_dcache #(.DC_SETS(DC_SETS)) lsu_dcache_inst (
        .i_clk(i_clk),
        .i_reset(i_reset),
        .i_flush(i_flush),
        .i_op_valid(ad_valid),
        .i_op(ad_op),
        .i_fill_valid(i_fill_valid),
        .i_fill(i_fill),
        .o_res_valid(res_valid),
        .o_res_op(res_op),
        .o_res_hit(res_hit),
        .o_res_word(res_word)
    );

    lsu_ex lsu_ex_inst (
        .i_clk(i_clk),
        .i_reset(i_reset),
        .i_flush(i_flush),
        .i_res_valid(res_valid),
        .i_res_op(res_op),
        .i_res_hit(res_hit),
        .i_res_word(res_word),
        .o_cdb_valid(o_cdb_valid),
        .o_cdb(o_cdb),
        .o_miss_valid(o_miss_valid),
        .o_miss(o_miss)
    );

endmodule

/* lsu_ex.sv */
// Result stage that extends load data and drives the completion bus and miss reports.
`timescale 1ns/1ps

module lsu_ex
    import lsu_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_flush,

    input  logic                  i_res_valid,
    input  lsu_op_t               i_res_op,
    input  logic                  i_res_hit,
    input  logic [DATA_WIDTH-1:0] i_res_word,

    output logic                  o_cdb_valid,
    output lsu_cdb_t              o_cdb,
    output logic                  o_miss_valid,
    output lsu_miss_t             o_miss
);

    logic [DATA_WIDTH-1:0] word;
    logic [DATA_WIDTH-1:0] load_data;
    logic [DATA_WIDTH-1:0] cdb_data;
    logic [ADDR_WIDTH-1:0] line_addr;

    assign word = i_res_word >> {i_res_op.addr[LANE_WIDTH-1:0], 3'b000};

    always_comb begin
        case (i_res_op.func)
            LSU_LB:  load_data = {{(DATA_WIDTH-8){word[7]}}, word[7:0]};
            LSU_LBU: load_data = {{(DATA_WIDTH-8){1'b0}}, word[7:0]};
            LSU_LH:  load_data = {{(DATA_WIDTH-16){word[15]}}, word[15:0]};
            LSU_LHU: load_data = {{(DATA_WIDTH-16){1'b0}}, word[15:0]};
            default: load_data = word;
        endcase
    end

    assign cdb_data  = lsu_is_store(i_res_op.func) ? '0 : load_data;   // stores complete with zero.
    assign line_addr = {i_res_op.addr[ADDR_WIDTH-1:LINE_OFFSET_WIDTH], {LINE_OFFSET_WIDTH{1'b0}}};

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_cdb_valid  <= 1'b0;
            o_miss_valid <= 1'b0;
        end else begin
            o_cdb_valid  <= i_res_valid & i_res_hit;
            o_miss_valid <= i_res_valid & ~i_res_hit;
        end
    end

    always_ff @(posedge i_clk) begin
        o_cdb  <= '{data: cdb_data, addr: i_res_op.addr, tag: i_res_op.tag};
        o_miss <= '{addr: line_addr, tag: i_res_op.tag};
    end

    a_one_strobe: assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_cdb_valid && o_miss_valid))
        else $error("completion and miss in the same cycle");

endmodule

/* lsu_dcache.sv */
// Direct-mapped data cache that reads its arrays, then compares tags, merges stores and writes fills.
`timescale 1ns/1ps

module lsu_dcache
    import lsu_pkg::*;
#(
    parameter int DC_SETS = 16
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_flush,

    input  logic                  i_op_valid,
    input  lsu_op_t               i_op,

    input  logic                  i_fill_valid,
    input  lsu_fill_t             i_fill,

    output logic                  o_res_valid,
    output lsu_op_t               o_res_op,
    output logic                  o_res_hit,
    output logic [DATA_WIDTH-1:0] o_res_word
);

    localparam int INDEX_WIDTH = $clog2(DC_SETS);
    localparam int DC_TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - LINE_OFFSET_WIDTH;

    typedef logic [DC_TAG_WIDTH-1:0] dc_tag_t;

    logic [DC_SETS-1:0]        set_valid;
    logic [INDEX_WIDTH-1:0]    ad_index;
    logic [INDEX_WIDTH-1:0]    dt_index;
    logic [INDEX_WIDTH-1:0]    fill_index;
    dc_tag_t                   dt_tag;
    dc_tag_t                   fill_tag;
    dc_tag_t                   tag_rd;
    dc_line_t                  line_rd;
    dc_line_t                  merged_line;
    dc_line_t                  line_wr_data;
    logic [INDEX_WIDTH-1:0]    line_wr_index;
    logic                      line_wr_en;
    logic [WORD_SEL_WIDTH-1:0] word_sel;
    logic [DATA_WIDTH-1:0]     sel_word;
    logic                      dt_valid;
    lsu_op_t                   dt_op;
    logic                      dt_store;
    logic                      hit;
    logic                      store_write;

    assign ad_index   = i_op.addr[LINE_OFFSET_WIDTH +: INDEX_WIDTH];
    assign dt_index   = dt_op.addr[LINE_OFFSET_WIDTH +: INDEX_WIDTH];
    assign dt_tag     = dt_op.addr[ADDR_WIDTH-1 -: DC_TAG_WIDTH];
    assign fill_index = i_fill.addr[LINE_OFFSET_WIDTH +: INDEX_WIDTH];
    assign fill_tag   = i_fill.addr[ADDR_WIDTH-1 -: DC_TAG_WIDTH];
    assign word_sel   = dt_op.addr[LANE_WIDTH +: WORD_SEL_WIDTH];
    assign sel_word   = line_rd[word_sel];
    assign dt_store   = lsu_is_store(dt_op.func);

    // a fill owns the write port, so a colliding store goes out as a miss.
    assign hit = set_valid[dt_index] && (tag_rd == dt_tag) && !(dt_store && i_fill_valid);
    assign store_write = dt_valid & ~i_flush & dt_store & hit;

    always_comb begin
        merged_line = line_rd;
        for (int b = 0; b < BYTE_LANES; b++) begin
            if (dt_op.mask[b]) begin
                merged_line[word_sel][8*b +: 8] = dt_op.data[8*b +: 8];
            end
        end
    end

    assign line_wr_en    = i_fill_valid | store_write;
    assign line_wr_index = i_fill_valid ? fill_index : dt_index;
    assign line_wr_data  = i_fill_valid ? i_fill.line : merged_line;

    dc_array #(.T(dc_tag_t), .DEPTH(DC_SETS)) tag_array_inst (
        .i_clk(i_clk),
        .i_rd_en(i_op_valid),
        .i_rd_index(ad_index),
        .o_rd_data(tag_rd),
        .i_wr_en(i_fill_valid),
        .i_wr_index(fill_index),
        .i_wr_data(fill_tag)
    );

    dc_array #(.T(dc_line_t), .DEPTH(DC_SETS)) line_array_inst (
        .i_clk(i_clk),
        .i_rd_en(i_op_valid),
        .i_rd_index(ad_index),
        .o_rd_data(line_rd),
        .i_wr_en(line_wr_en),
        .i_wr_index(line_wr_index),
        .i_wr_data(line_wr_data)
    );

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            set_valid   <= '0;
            dt_valid    <= 1'b0;
            o_res_valid <= 1'b0;
            o_res_hit   <= 1'b0;
        end else begin
            if (i_fill_valid) begin
                set_valid[fill_index] <= 1'b1;
            end
            dt_valid    <= i_op_valid & ~i_flush;
            o_res_valid <= dt_valid & ~i_flush;
            o_res_hit   <= dt_valid & ~i_flush & hit;
        end
    end

    always_ff @(posedge i_clk) begin
        dt_op      <= i_op;
        o_res_op   <= dt_op;
        o_res_word <= sel_word;
    end

    a_hit_valid: assert property (@(posedge i_clk) disable iff (i_reset)
        o_res_hit |-> o_res_valid)
        else $error("hit without a valid result");

endmodule

/* lsu_agu.sv */
// Address generation stage that forms the byte address and lane mask and registers the operation.
`timescale 1ns/1ps

module lsu_agu
    import lsu_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_reset,

    input  logic     i_flush,
    input  logic     i_req_valid,
    input  lsu_req_t i_req,

    output logic     o_op_valid,
    output lsu_op_t  o_op
);

    logic [ADDR_WIDTH-1:0] addr;
    logic [LANE_WIDTH-1:0] lane;
    logic [BYTE_LANES-1:0] size_mask;
    logic [BYTE_LANES-1:0] byte_mask;
    logic [DATA_WIDTH-1:0] lane_data;

    assign addr = i_req.base + i_req.offset;
    assign lane = addr[LANE_WIDTH-1:0];

    always_comb begin
        case (i_req.func)
            LSU_LB, LSU_LBU, LSU_SB: size_mask = BYTE_LANES'(1);
            LSU_LH, LSU_LHU, LSU_SH: size_mask = BYTE_LANES'(3);
            default:                 size_mask = '1;
        endcase
    end

    assign byte_mask = size_mask << lane;
    assign lane_data = i_req.data << {lane, 3'b000};   // into its byte lane.

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_op_valid <= 1'b0;
        end else begin
            o_op_valid <= i_req_valid & ~i_flush;
        end
    end

    always_ff @(posedge i_clk) begin
        o_op <= '{func: i_req.func, addr: addr, data: lane_data, mask: byte_mask, tag: i_req.tag};
    end

    // upper size mask bits give the address bits that must be clear.
    a_aligned: assert property (@(posedge i_clk) disable iff (i_reset)
        i_req_valid |-> (lane & size_mask[LANE_WIDTH:1]) == '0)
        else $error("misaligned access at %h", addr);

endmodule

/* dc_array.sv */
// Cache storage array with one registered read port, one write port and write-first bypass.
`timescale 1ns/1ps

module dc_array #(
    parameter type T     = logic,
    parameter int  DEPTH = 16
) (
    input  logic                     i_clk,

    input  logic                     i_rd_en,
    input  logic [$clog2(DEPTH)-1:0] i_rd_index,
    output T                         o_rd_data,

    input  logic                     i_wr_en,
    input  logic [$clog2(DEPTH)-1:0] i_wr_index,
    input  T                         i_wr_data
);

    T mem [DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_index] <= i_wr_data;
        end
    end

    // same index written this cycle returns the new value.
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            if (i_wr_en && (i_wr_index == i_rd_index)) begin
                o_rd_data <= i_wr_data;
            end else begin
                o_rd_data <= mem[i_rd_index];
            end
        end
    end

endmodule

/* lsu_pkg.sv */
// Load/store unit package with widths, operation encoding and the structs between stages.
package lsu_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int TAG_WIDTH = 5;   // reorder buffer tag.
    localparam int LINE_WORDS = 4;

    localparam int BYTE_LANES = DATA_WIDTH / 8;
    localparam int LANE_WIDTH = $clog2(BYTE_LANES);
    localparam int WORD_SEL_WIDTH = $clog2(LINE_WORDS);
    localparam int LINE_OFFSET_WIDTH = LANE_WIDTH + WORD_SEL_WIDTH;

    typedef enum logic [2:0] {
        LSU_LB  = 3'd0,
        LSU_LH  = 3'd1,
        LSU_LW  = 3'd2,
        LSU_LBU = 3'd3,
        LSU_LHU = 3'd4,
        LSU_SB  = 3'd5,
        LSU_SH  = 3'd6,
        LSU_SW  = 3'd7
    } lsu_func_t;

    typedef logic [LINE_WORDS-1:0][DATA_WIDTH-1:0] dc_line_t;

    // operation as issued, before address generation.
    typedef struct packed {
        lsu_func_t              func;
        logic [ADDR_WIDTH-1:0]  base;
        logic [ADDR_WIDTH-1:0]  offset;
        logic [DATA_WIDTH-1:0]  data;
        logic [TAG_WIDTH-1:0]   tag;
    } lsu_req_t;

    // store data already sits in its byte lanes.
    typedef struct packed {
        lsu_func_t              func;
        logic [ADDR_WIDTH-1:0]  addr;
        logic [DATA_WIDTH-1:0]  data;
        logic [BYTE_LANES-1:0]  mask;
        logic [TAG_WIDTH-1:0]   tag;
    } lsu_op_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]  data;
        logic [ADDR_WIDTH-1:0]  addr;
        logic [TAG_WIDTH-1:0]   tag;
    } lsu_cdb_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0]  addr;   // line aligned.
        logic [TAG_WIDTH-1:0]   tag;
    } lsu_miss_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0]  addr;
        dc_line_t               line;
    } lsu_fill_t;

    function automatic logic lsu_is_store(lsu_func_t func);
        return func inside {LSU_SB, LSU_SH, LSU_SW};
    endfunction

endpackage
